//--- rtl/arf.sv
//####################
// 32 architectural registers, r0 is never written
// Reads return one cycle after re
//####################
`timescale 1ns/10ps
`default_nettype none
`include "ooo_config.svh"

module arf (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   re1,
   input  logic                   re2,
   input  logic [`OOO_REG_AW-1:0] addr1,
   input  logic [`OOO_REG_AW-1:0] addr2,
   output logic [`OOO_DW-1:0]     dat1,
   output logic [`OOO_DW-1:0]     dat2,
   input  ooo_pkg::commit_t       commit
);
   localparam int NREG = 1 << `OOO_REG_AW;

   logic [`OOO_DW-1:0] regs [NREG];

   // All registers clear on reset, r0 stays zero after that
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NREG; i++)
            regs[i] <= '0;
      end
      else if (commit.valid && commit.rd_addr != '0)
         regs[commit.rd_addr] <= commit.dat;
   end

   // Old value is read when a commit hits the same register
   always_ff @(posedge clk)
   begin
      if (re1)
         dat1 <= regs[addr1];
      if (re2)
         dat2 <= regs[addr2];
   end

endmodule

`default_nettype wire

//--- rtl/dispatch.sv
//####################
// One insn per cycle into ROB and one of four issue queues
// Upstream must select exactly one unit per insn
//####################
`timescale 1ns/10ps
`default_nettype none
`include "ooo_config.svh"

module dispatch (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            disp_valid,
   input  ooo_pkg::disp_insn_t             disp_insn,
   output logic                            disp_ready,
   input  logic                            rob_ready,
   output logic                            alloc,
   input  logic [`OOO_ROB_DEPTH_LOG2-1:0]  alloc_id,
   input  ooo_pkg::rob_lookup_t            rs1_look,
   input  ooo_pkg::rob_lookup_t            rs2_look,
   output logic                            arf_re1,
   output logic                            arf_re2,
   output logic [`OOO_REG_AW-1:0]          arf_addr1,
   output logic [`OOO_REG_AW-1:0]          arf_addr2,
   input  logic [`OOO_DW-1:0]              arf_dat1,
   input  logic [`OOO_DW-1:0]              arf_dat2,
   input  logic [3:0]                      iq_space,
   output logic [3:0]                      enq,
   output ooo_pkg::iq_entry_t              enq_entry
);
   import ooo_pkg::*;

   logic                           accept;
   logic [3:0]                     sel;
   unit_e                          unit_nxt;
   alu_opc_e                       alu_opc;
   lpu_opc_e                       lpu_opc;
   epu_opc_e                       epu_opc;
   uop_t                           uop_nxt;
   logic                           valid_q;
   unit_e                          unit_q;
   logic [`OOO_ROB_DEPTH_LOG2-1:0] id_q;
   uop_t                           uop_q;
   logic [`OOO_DW-1:0]             imm_q;
   logic                           rs1_re_q;
   logic                           rs2_re_q;
   rob_lookup_t                    look1_q;
   rob_lookup_t                    look2_q;

   // Immediate when not read, else ARF, ROB or wait on the producer tag
   function automatic operand_t make_op(input logic re, input rob_lookup_t look,
                                        input logic [`OOO_DW-1:0] arf_dat,
                                        input logic [`OOO_DW-1:0] imm);
      operand_t op;
      op.tag = look.id;
      op.rdy = !re || look.in_arf || look.in_rob;
      if (!re)
         op.dat = imm;
      else if (look.in_arf)
         op.dat = arf_dat;
      else
         op.dat = look.dat;
      return op;
   endfunction

   assign sel[UNIT_ALU] = |disp_insn.alu_opc_bus;
   assign sel[UNIT_LPU] = |disp_insn.lpu_opc_bus;
   assign sel[UNIT_AGU] = disp_insn.agu_load | disp_insn.agu_store;
   assign sel[UNIT_EPU] = |disp_insn.epu_opc_bus;

   assign disp_ready = rob_ready & |(sel & iq_space);
   assign accept = disp_valid & disp_ready;
   assign alloc = accept;

   // ARF read is the pipeline register for committed operands
   assign arf_re1 = disp_insn.rs1_re & accept;
   assign arf_re2 = disp_insn.rs2_re & accept;
   assign arf_addr1 = disp_insn.rs1_addr;
   assign arf_addr2 = disp_insn.rs2_addr;

   // Lowest set bit wins, loops run high to low
   always_comb
   begin
      alu_opc = ALU_NOP;
      lpu_opc = LPU_NOP;
      epu_opc = EPU_NOP;
      for (int i = 16; i >= 0; i--)
         if (disp_insn.alu_opc_bus[i])
            alu_opc = alu_opc_e'(5'(i + 1));
      for (int i = 4; i >= 0; i--)
         if (disp_insn.lpu_opc_bus[i])
            lpu_opc = lpu_opc_e'(3'(i + 1));
      for (int i = 6; i >= 0; i--)
         if (disp_insn.epu_opc_bus[i])
            epu_opc = epu_opc_e'(3'(i + 1));
   end

   always_comb
   begin
      unit_nxt = UNIT_ALU;
      if (sel[UNIT_LPU])
         unit_nxt = UNIT_LPU;
      if (sel[UNIT_AGU])
         unit_nxt = UNIT_AGU;
      if (sel[UNIT_EPU])
         unit_nxt = UNIT_EPU;
      uop_nxt = '0;
      case (unit_nxt)
         UNIT_ALU:
         begin
            uop_nxt.alu.rel15 = disp_insn.rel15;
            uop_nxt.alu.opc = alu_opc;
         end
         UNIT_LPU:
            uop_nxt.lpu.opc = lpu_opc;
         UNIT_AGU:
         begin
            uop_nxt.agu.load = disp_insn.agu_load;
            uop_nxt.agu.store = disp_insn.agu_store;
            uop_nxt.agu.barr = disp_insn.agu_barr;
            uop_nxt.agu.sign_ext = disp_insn.agu_sign_ext;
            uop_nxt.agu.size = disp_insn.agu_load ? disp_insn.agu_load_size
                                                  : disp_insn.agu_store_size;
         end
         default:
            uop_nxt.epu.opc = epu_opc;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid_q <= 1'b0;
      else
         valid_q <= accept;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         unit_q <= unit_nxt;
         id_q <= alloc_id;
         uop_q <= uop_nxt;
         imm_q <= disp_insn.imm32;
         rs1_re_q <= disp_insn.rs1_re;
         rs2_re_q <= disp_insn.rs2_re;
         look1_q <= rs1_look;
         look2_q <= rs2_look;
      end
   end

   assign enq = valid_q ? (4'b0001 << unit_q) : 4'b0000;
   assign enq_entry.id = id_q;
   assign enq_entry.uop = uop_q;
   assign enq_entry.op1 = make_op(rs1_re_q, look1_q, arf_dat1, imm_q);
   assign enq_entry.op2 = make_op(rs2_re_q, look2_q, arf_dat2, imm_q);
   assign enq_entry.imm32 = imm_q;

   a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
      accept |-> $onehot(sel));
   a_look_excl: assert property (@(posedge clk) disable iff (!rst_n)
      accept |-> !(rs1_look.in_rob && rs1_look.in_arf) &&
                 !(rs2_look.in_rob && rs2_look.in_arf));

endmodule

`default_nettype wire

//--- rtl/dispatch_top.sv
//####################
// Dispatch, ROB, ARF and four issue queues
// Execution units sit outside and drive wb and the pops
//####################
`timescale 1ns/10ps
`default_nettype none
`include "ooo_config.svh"

module dispatch_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                disp_valid,
   input  ooo_pkg::disp_insn_t disp_insn,
   output logic                disp_ready,
   input  ooo_pkg::wb_t        wb,
   output logic                iq_alu_valid,
   output ooo_pkg::iq_entry_t  iq_alu_head,
   input  logic                iq_alu_pop,
   output logic                iq_lpu_valid,
   output ooo_pkg::iq_entry_t  iq_lpu_head,
   input  logic                iq_lpu_pop,
   output logic                iq_agu_valid,
   output ooo_pkg::iq_entry_t  iq_agu_head,
   input  logic                iq_agu_pop,
   output logic                iq_epu_valid,
   output ooo_pkg::iq_entry_t  iq_epu_head,
   input  logic                iq_epu_pop
);
   import ooo_pkg::*;

   logic                           rob_ready;
   logic                           alloc;
   logic [`OOO_ROB_DEPTH_LOG2-1:0] alloc_id;
   rob_lookup_t                    rs1_look;
   rob_lookup_t                    rs2_look;
   logic                           arf_re1;
   logic                           arf_re2;
   logic [`OOO_REG_AW-1:0]         arf_addr1;
   logic [`OOO_REG_AW-1:0]         arf_addr2;
   logic [`OOO_DW-1:0]             arf_dat1;
   logic [`OOO_DW-1:0]             arf_dat2;
   commit_t                        commit;
   logic [3:0]                     iq_space;
   logic [3:0]                     enq;
   iq_entry_t                      enq_entry;

   dispatch u_dispatch (
      .clk, .rst_n, .disp_valid, .disp_insn, .disp_ready,
      .rob_ready, .alloc, .alloc_id, .rs1_look, .rs2_look,
      .arf_re1, .arf_re2, .arf_addr1, .arf_addr2, .arf_dat1, .arf_dat2,
      .iq_space, .enq, .enq_entry
   );

   rob u_rob (
      .clk, .rst_n, .alloc, .alloc_insn(disp_insn), .alloc_id, .rob_ready,
      .rs1_look, .rs2_look, .wb, .commit
   );

   arf u_arf (
      .clk, .rst_n, .re1(arf_re1), .re2(arf_re2), .addr1(arf_addr1),
      .addr2(arf_addr2), .dat1(arf_dat1), .dat2(arf_dat2), .commit
   );

   // One queue per unit, indexed by unit_e
   issue_queue u_iq_alu (
      .clk, .rst_n, .enq(enq[UNIT_ALU]), .enq_entry, .space(iq_space[UNIT_ALU]),
      .wb, .valid(iq_alu_valid), .head(iq_alu_head), .pop(iq_alu_pop)
   );

   issue_queue u_iq_lpu (
      .clk, .rst_n, .enq(enq[UNIT_LPU]), .enq_entry, .space(iq_space[UNIT_LPU]),
      .wb, .valid(iq_lpu_valid), .head(iq_lpu_head), .pop(iq_lpu_pop)
   );

   issue_queue u_iq_agu (
      .clk, .rst_n, .enq(enq[UNIT_AGU]), .enq_entry, .space(iq_space[UNIT_AGU]),
      .wb, .valid(iq_agu_valid), .head(iq_agu_head), .pop(iq_agu_pop)
   );

   issue_queue u_iq_epu (
      .clk, .rst_n, .enq(enq[UNIT_EPU]), .enq_entry, .space(iq_space[UNIT_EPU]),
      .wb, .valid(iq_epu_valid), .head(iq_epu_head), .pop(iq_epu_pop)
   );

endmodule

`default_nettype wire

//--- rtl/issue_queue.sv
//####################
// In-order issue FIFO with operand wakeup from writeback
// DEPTH is a power of two, at least 2
//####################
`timescale 1ns/10ps
`default_nettype none
`include "ooo_config.svh"

module issue_queue #(
   parameter int DEPTH = `OOO_IQ_DEPTH
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               enq,
   input  ooo_pkg::iq_entry_t enq_entry,
   output logic               space,
   input  ooo_pkg::wb_t       wb,
   output logic               valid,
   output ooo_pkg::iq_entry_t head,
   input  logic               pop
);
   import ooo_pkg::*;

   localparam int PW = $clog2(DEPTH);

   iq_entry_t   mem [DEPTH];
   iq_entry_t   in_ent;
   logic [PW:0] wr_ptr;
   logic [PW:0] rd_ptr;
   logic [PW:0] used;
   wb_t         wb_q;

   function automatic operand_t wake(input operand_t op, input wb_t w);
      operand_t r;
      r = op;
      if (!op.rdy && w.valid && w.id == op.tag)
      begin
         r.rdy = 1'b1;
         r.dat = w.dat;
      end
      return r;
   endfunction

   assign used = wr_ptr - rd_ptr;
   assign valid = (used != '0);
   // Two free slots so the entry already in dispatch still fits
   assign space = (used <= (PW + 1)'(DEPTH - 2));

   // Incoming entry missed the writeback of the cycle its lookup was taken
   always_comb
   begin
      in_ent = enq_entry;
      in_ent.op1 = wake(wake(enq_entry.op1, wb_q), wb);
      in_ent.op2 = wake(wake(enq_entry.op2, wb_q), wb);
   end

   always_comb
   begin
      head = mem[rd_ptr[PW-1:0]];
      head.op1 = wake(mem[rd_ptr[PW-1:0]].op1, wb);
      head.op2 = wake(mem[rd_ptr[PW-1:0]].op2, wb);
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         mem[i].op1 <= wake(mem[i].op1, wb);
         mem[i].op2 <= wake(mem[i].op2, wb);
      end
      if (enq)
         mem[wr_ptr[PW-1:0]] <= in_ent;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         wb_q <= '0;
      end
      else
      begin
         wb_q <= wb;
         if (enq)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop && valid)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> valid);

endmodule

`default_nettype wire

//--- rtl/ooo_config.svh
//####################
// Widths and depths shared by the dispatch stage
// ROB depth is a power of two; queue depth must be a power of two, at least 2
//####################
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// Data and PC widths, PC is a word address
`define OOO_DW 32
`define OOO_AW 30

`define OOO_REG_AW 5

// Eight ROB entries
`define OOO_ROB_DEPTH_LOG2 3

`define OOO_IQ_DEPTH 4

`endif

//--- rtl/ooo_pkg.sv
//####################
// Opcode enums and the structs passed between the stage blocks
// No FPU micro-op, the FPU path is not present
//####################
`default_nettype none
`include "ooo_config.svh"

package ooo_pkg;

   // Value is one plus the lowest set bit of the one-hot bus
   typedef enum logic [4:0] {
      ALU_NOP, ALU_OP1, ALU_OP2, ALU_OP3, ALU_OP4, ALU_OP5, ALU_OP6,
      ALU_OP7, ALU_OP8, ALU_OP9, ALU_OP10, ALU_OP11, ALU_OP12,
      ALU_OP13, ALU_OP14, ALU_OP15, ALU_OP16, ALU_OP17
   } alu_opc_e;

   typedef enum logic [2:0] {
      LPU_NOP, LPU_OP1, LPU_OP2, LPU_OP3, LPU_OP4, LPU_OP5
   } lpu_opc_e;

   typedef enum logic [2:0] {
      EPU_NOP, EPU_OP1, EPU_OP2, EPU_OP3, EPU_OP4, EPU_OP5, EPU_OP6, EPU_OP7
   } epu_opc_e;

   typedef enum logic [1:0] {
      UNIT_ALU, UNIT_LPU, UNIT_AGU, UNIT_EPU
   } unit_e;

   typedef struct packed {
      logic [`OOO_AW-1:0]     pc;
      logic                   pred_branch;
      logic [`OOO_AW-1:0]     pred_tgt;
      logic [16:0]            alu_opc_bus;
      logic [4:0]             lpu_opc_bus;
      logic [6:0]             epu_opc_bus;
      logic                   agu_load;
      logic                   agu_store;
      logic                   agu_sign_ext;
      logic                   agu_barr;
      logic [2:0]             agu_load_size;
      logic [2:0]             agu_store_size;
      logic                   rs1_re;
      logic [`OOO_REG_AW-1:0] rs1_addr;
      logic                   rs2_re;
      logic [`OOO_REG_AW-1:0] rs2_addr;
      logic [`OOO_DW-1:0]     imm32;
      logic [14:0]            rel15;
      logic                   rd_we;
      logic [`OOO_REG_AW-1:0] rd_addr;
   } disp_insn_t;

   typedef struct packed {
      logic                           rdy;
      logic [`OOO_ROB_DEPTH_LOG2-1:0] tag;
      logic [`OOO_DW-1:0]             dat;
   } operand_t;

   // Micro-op views, all 20 bits wide
   typedef struct packed {
      logic [14:0] rel15;
      alu_opc_e    opc;
   } alu_uop_t;

   typedef struct packed {
      logic [16:0] pad;
      lpu_opc_e    opc;
   } lpu_uop_t;

   typedef struct packed {
      logic [12:0] pad;
      logic        load;
      logic        store;
      logic        barr;
      logic        sign_ext;
      logic [2:0]  size;
   } agu_uop_t;

   typedef struct packed {
      logic [16:0] pad;
      epu_opc_e    opc;
   } epu_uop_t;

   typedef union packed {
      alu_uop_t alu;
      lpu_uop_t lpu;
      agu_uop_t agu;
      epu_uop_t epu;
   } uop_t;

   typedef struct packed {
      logic [`OOO_ROB_DEPTH_LOG2-1:0] id;
      uop_t                           uop;
      operand_t                       op1;
      operand_t                       op2;
      logic [`OOO_DW-1:0]             imm32;
   } iq_entry_t;

   typedef struct packed {
      logic                           valid;
      logic [`OOO_ROB_DEPTH_LOG2-1:0] id;
      logic [`OOO_DW-1:0]             dat;
   } wb_t;

   typedef struct packed {
      logic                   valid;
      logic [`OOO_REG_AW-1:0] rd_addr;
      logic [`OOO_DW-1:0]     dat;
   } commit_t;

   // Neither flag set means the producer is still pending under id
   typedef struct packed {
      logic                           in_rob;
      logic                           in_arf;
      logic [`OOO_DW-1:0]             dat;
      logic [`OOO_ROB_DEPTH_LOG2-1:0] id;
   } rob_lookup_t;

endpackage

`default_nettype wire

//--- rtl/rob.sv
//####################
// Eight-entry reorder buffer, one writeback and one commit per cycle
// Entries without rd_we are done at allocation; no flush
//####################
`timescale 1ns/10ps
`default_nettype none
`include "ooo_config.svh"

module rob (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            alloc,
   input  ooo_pkg::disp_insn_t             alloc_insn,
   output logic [`OOO_ROB_DEPTH_LOG2-1:0]  alloc_id,
   output logic                            rob_ready,
   output ooo_pkg::rob_lookup_t            rs1_look,
   output ooo_pkg::rob_lookup_t            rs2_look,
   input  ooo_pkg::wb_t                    wb,
   output ooo_pkg::commit_t                commit
);
   import ooo_pkg::*;

   localparam int IW = `OOO_ROB_DEPTH_LOG2;
   localparam int DEPTH = 1 << IW;
   localparam int NREG = 1 << `OOO_REG_AW;

   // Pointers carry a wrap bit to tell full from empty
   logic [IW:0]            head;
   logic [IW:0]            tail;
   logic [DEPTH-1:0]       busy;
   logic [DEPTH-1:0]       done;
   logic [DEPTH-1:0]       ent_we;
   logic [`OOO_REG_AW-1:0] ent_rd [DEPTH];
   logic [`OOO_DW-1:0]     ent_dat [DEPTH];
   logic [NREG-1:0]        ren_valid;
   logic [IW-1:0]          ren_id [NREG];
   logic                   full;
   logic                   retire;
   logic [IW-1:0]          hd;
   logic [`OOO_REG_AW-1:0] hd_rd;

   function automatic rob_lookup_t lookup(input logic [`OOO_REG_AW-1:0] addr);
      rob_lookup_t l;
      l.id = ren_id[addr];
      l.dat = ent_dat[l.id];
      l.in_arf = !ren_valid[addr];
      l.in_rob = ren_valid[addr] && done[l.id];
      return l;
   endfunction

   assign full = (head[IW] != tail[IW]) && (head[IW-1:0] == tail[IW-1:0]);
   assign rob_ready = !full;
   assign alloc_id = tail[IW-1:0];
   assign hd = head[IW-1:0];
   assign hd_rd = ent_rd[hd];
   assign retire = busy[hd] && done[hd];

   // Registered state only, same-cycle writeback is not forwarded
   always_comb
   begin
      rs1_look = lookup(alloc_insn.rs1_addr);
      rs2_look = lookup(alloc_insn.rs2_addr);
   end

   assign commit.valid = retire && ent_we[hd];
   assign commit.rd_addr = hd_rd;
   assign commit.dat = ent_dat[hd];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         head <= '0;
         tail <= '0;
         busy <= '0;
         done <= '0;
         ren_valid <= '0;
      end
      else
      begin
         if (retire)
         begin
            busy[hd] <= 1'b0;
            head <= head + 1'b1;
            // Drop the mapping only if no younger producer took over
            if (ent_we[hd] && ren_id[hd_rd] == hd)
               ren_valid[hd_rd] <= 1'b0;
         end
         if (wb.valid)
            done[wb.id] <= 1'b1;
         if (alloc)
         begin
            busy[alloc_id] <= 1'b1;
            done[alloc_id] <= !alloc_insn.rd_we;
            tail <= tail + 1'b1;
            if (alloc_insn.rd_we && alloc_insn.rd_addr != '0)
               ren_valid[alloc_insn.rd_addr] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (alloc)
      begin
         ent_we[alloc_id] <= alloc_insn.rd_we;
         ent_rd[alloc_id] <= alloc_insn.rd_addr;
         // Only a writer becomes the newest producer
         if (alloc_insn.rd_we)
            ren_id[alloc_insn.rd_addr] <= alloc_id;
      end
      if (wb.valid)
         ent_dat[wb.id] <= wb.dat;
   end

   a_wb_live: assert property (@(posedge clk) disable iff (!rst_n)
      wb.valid |-> busy[wb.id] && !done[wb.id]);
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      alloc |-> !full);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dispatch_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="Finished with no errors"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dispatch_top -f src.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- src.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/dispatch.sv
rtl/rob.sv
rtl/arf.sv
rtl/issue_queue.sv
rtl/dispatch_top.sv
tests/tb_dispatch_top.sv

//--- tests/tb_dispatch_top.sv
//####################
// Random insns through dispatch_top, the TB plays the execution units
// Pops only heads with both operands ready, one pop per two cycles per unit
//####################
`timescale 1ns/10ps
`default_nettype none
`include "ooo_config.svh"

module tb_dispatch_top;
   import ooo_pkg::*;

   localparam int N_INSN = 400;
   localparam int SW = 10;
   localparam int IW = `OOO_ROB_DEPTH_LOG2;
   localparam int CLK_NS = 40;
   localparam longint WATCH_NS = 64'(N_INSN) * 10 * CLK_NS;

   // Expected queue entry, sources named by the sequence number of their writer
   typedef struct packed {
      logic [SW-1:0]      seq;
      logic [19:0]        uop;
      logic [`OOO_DW-1:0] imm;
      logic               rd_we;
      logic               re1;
      logic               has1;
      logic [SW-1:0]      src1;
      logic               re2;
      logic               has2;
      logic [SW-1:0]      src2;
   } exp_t;

   logic               clk;
   logic               rst_n;
   logic               disp_valid;
   disp_insn_t         disp_insn;
   logic               disp_ready;
   wb_t                wb;
   logic [3:0]         pop;
   logic [3:0]         valids;
   iq_entry_t          heads [4];
   exp_t               front [4];
   int                 exp_cnt [4];
   logic [`OOO_DW-1:0] wbdat [N_INSN];
   exp_t               expq [4][$];
   exp_t               pending [$];
   logic               last_valid [32];
   logic [SW-1:0]      last_seq [32];
   logic [19:0]        cur_uop;
   int                 cur_unit;
   int                 n_disp;
   int                 cyc;
   logic               started;
   string              unit_name [4] = '{"alu", "lpu", "agu", "epu"};

   dispatch_top u_dispatch_top (
      .clk, .rst_n, .disp_valid, .disp_insn, .disp_ready, .wb,
      .iq_alu_valid(valids[UNIT_ALU]), .iq_alu_head(heads[UNIT_ALU]),
      .iq_alu_pop(pop[UNIT_ALU]),
      .iq_lpu_valid(valids[UNIT_LPU]), .iq_lpu_head(heads[UNIT_LPU]),
      .iq_lpu_pop(pop[UNIT_LPU]),
      .iq_agu_valid(valids[UNIT_AGU]), .iq_agu_head(heads[UNIT_AGU]),
      .iq_agu_pop(pop[UNIT_AGU]),
      .iq_epu_valid(valids[UNIT_EPU]), .iq_epu_head(heads[UNIT_EPU]),
      .iq_epu_pop(pop[UNIT_EPU])
   );

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      stop_run("Value mismatch on an issue queue head");
   endtask

   // Random insn for one unit, with the micro-op it must encode to
   task automatic make_insn(output disp_insn_t i, output logic [19:0] u, output int unit);
      int k;
      i = '0;
      unit = int'($urandom % 4);
      i.pc = 30'($urandom);
      i.pred_branch = 1'($urandom);
      i.pred_tgt = 30'($urandom);
      i.rs1_re = ($urandom % 4) != 0;
      i.rs1_addr = 5'($urandom % 8);
      i.rs2_re = ($urandom % 4) != 0;
      i.rs2_addr = 5'($urandom % 8);
      i.imm32 = $urandom;
      i.rel15 = 15'($urandom);
      i.rd_we = ($urandom % 4) != 0;
      i.rd_addr = 5'($urandom % 8);
      i.agu_sign_ext = 1'($urandom);
      i.agu_barr = 1'($urandom);
      i.agu_load_size = 3'($urandom);
      i.agu_store_size = 3'($urandom);
      case (unit)
         0:
         begin
            k = int'($urandom % 17);
            i.alu_opc_bus = 17'd1 << k;
            u = {i.rel15, 5'(k + 1)};
         end
         1:
         begin
            k = int'($urandom % 5);
            i.lpu_opc_bus = 5'd1 << k;
            u = {17'd0, 3'(k + 1)};
         end
         2:
         begin
            if ($urandom % 2 == 0)
               i.agu_load = 1'b1;
            else
               i.agu_store = 1'b1;
            u = {13'd0, i.agu_load, i.agu_store, i.agu_barr, i.agu_sign_ext,
                 i.agu_load ? i.agu_load_size : i.agu_store_size};
         end
         default:
         begin
            k = int'($urandom % 7);
            i.epu_opc_bus = 7'd1 << k;
            u = {17'd0, 3'(k + 1)};
         end
      endcase
   endtask

   function automatic logic [`OOO_DW-1:0] op_exp(input logic re, input logic has,
                                                 input logic [SW-1:0] src,
                                                 input logic [`OOO_DW-1:0] imm);
      if (!re)
         return imm;
      return has ? wbdat[src] : '0;
   endfunction

   // Not-ready operands must wait on the writer's ROB id
   function automatic logic op_ok(input operand_t op, input logic re, input logic has,
                                  input logic [SW-1:0] src, input logic [`OOO_DW-1:0] imm);
      if (!re)
         return op.rdy && op.dat == imm;
      if (!op.rdy)
         return has && op.tag == src[IW-1:0];
      return op.dat == op_exp(re, has, src, imm);
   endfunction

   // Each unit is held off for 64 cycles in turn
   function automatic logic stalled(input int u);
      return ((cyc / 64) % 5) == u + 1;
   endfunction

   function automatic int queued_total();
      int n;
      n = pending.size();
      for (int u = 0; u < 4; u++)
         n += expq[u].size();
      return n;
   endfunction

   a_reset: assert property (@(posedge clk) $rose(rst_n) |-> disp_ready && valids == 4'b0)
      else stop_run("Dispatch not ready or a queue not empty after reset");

   for (genvar u = 0; u < 4; u++)
   begin : g_chk
      a_fill: assert property (@(posedge clk) disable iff (!rst_n)
         exp_cnt[u] <= `OOO_IQ_DEPTH)
         else stop_run($sformatf("Queue %s accepted more entries than it holds", unit_name[u]));
      a_known: assert property (@(posedge clk) disable iff (!rst_n)
         valids[u] |-> exp_cnt[u] != 0)
         else stop_run($sformatf("Queue %s shows an entry never sent to it", unit_name[u]));
      a_id: assert property (@(posedge clk) disable iff (!rst_n)
         valids[u] |-> heads[u].id == front[u].seq[IW-1:0])
         else report_value($sformatf("iq_%s_head.id", unit_name[u]),
                           64'(heads[u].id), 64'(front[u].seq[IW-1:0]));
      a_uop: assert property (@(posedge clk) disable iff (!rst_n)
         valids[u] |-> 20'(heads[u].uop) == front[u].uop)
         else report_value($sformatf("iq_%s_head.uop", unit_name[u]),
                           64'(heads[u].uop), 64'(front[u].uop));
      a_imm: assert property (@(posedge clk) disable iff (!rst_n)
         valids[u] |-> heads[u].imm32 == front[u].imm)
         else report_value($sformatf("iq_%s_head.imm32", unit_name[u]),
                           64'(heads[u].imm32), 64'(front[u].imm));
      a_op1: assert property (@(posedge clk) disable iff (!rst_n)
         valids[u] |-> op_ok(heads[u].op1, front[u].re1, front[u].has1,
                             front[u].src1, front[u].imm))
         else report_value($sformatf("iq_%s_head.op1", unit_name[u]), 64'(heads[u].op1),
                           64'(op_exp(front[u].re1, front[u].has1, front[u].src1,
                                      front[u].imm)));
      a_op2: assert property (@(posedge clk) disable iff (!rst_n)
         valids[u] |-> op_ok(heads[u].op2, front[u].re2, front[u].has2,
                             front[u].src2, front[u].imm))
         else report_value($sformatf("iq_%s_head.op2", unit_name[u]), 64'(heads[u].op2),
                           64'(op_exp(front[u].re2, front[u].has2, front[u].src2,
                                      front[u].imm)));
   end

   initial
   begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial
   begin
      #(WATCH_NS);
      stop_run("Watchdog timeout, the run did not finish in time");
   end

   // Execution units, writeback and dispatch driver
   always @(posedge clk)
   begin
      exp_t               e;
      exp_t               f;
      int                 idx;
      logic [`OOO_DW-1:0] d;
      disp_insn_t         ni;
      logic [19:0]        nu;
      int                 nunit;
      if (rst_n)
      begin
         cyc <= cyc + 1;
         for (int u = 0; u < 4; u++)
         begin
            if (pop[u])
            begin
               f = expq[u].pop_front();
               if (f.rd_we)
                  pending.push_back(f);
               pop[u] <= 1'b0;
            end
            else if (valids[u] && heads[u].op1.rdy && heads[u].op2.rdy && !stalled(u) &&
                     $urandom % 4 != 0)
               pop[u] <= 1'b1;
         end
         // One writeback per cycle, picked at random among finished ops
         wb <= '0;
         if (pending.size() != 0 && $urandom % 2 == 0)
         begin
            idx = int'($urandom % pending.size());
            f = pending[idx];
            pending.delete(idx);
            d = $urandom;
            wb <= {1'b1, f.seq[IW-1:0], d};
            wbdat[f.seq] <= d;
         end
         if (disp_valid && disp_ready)
         begin
            e.seq = SW'(n_disp);
            e.uop = cur_uop;
            e.imm = disp_insn.imm32;
            e.rd_we = disp_insn.rd_we;
            e.re1 = disp_insn.rs1_re;
            e.has1 = last_valid[disp_insn.rs1_addr];
            e.src1 = last_seq[disp_insn.rs1_addr];
            e.re2 = disp_insn.rs2_re;
            e.has2 = last_valid[disp_insn.rs2_addr];
            e.src2 = last_seq[disp_insn.rs2_addr];
            // Sources see the older writer, then this insn renames rd
            if (disp_insn.rd_we && disp_insn.rd_addr != '0)
            begin
               last_valid[disp_insn.rd_addr] = 1'b1;
               last_seq[disp_insn.rd_addr] = SW'(n_disp);
            end
            expq[cur_unit].push_back(e);
            n_disp++;
         end
         if (!started || (disp_valid && disp_ready))
         begin
            started = 1'b1;
            if (n_disp < N_INSN)
            begin
               make_insn(ni, nu, nunit);
               disp_insn <= ni;
               cur_uop <= nu;
               cur_unit <= nunit;
               disp_valid <= 1'b1;
            end
            else
               disp_valid <= 1'b0;
         end
         for (int u = 0; u < 4; u++)
         begin
            front[u] <= (expq[u].size() != 0) ? expq[u][0] : '0;
            exp_cnt[u] <= expq[u].size();
         end
      end
   end

   initial
   begin
      void'($urandom(50240));
      rst_n = 1'b0;
      disp_valid = 1'b0;
      disp_insn = '0;
      disp_insn.alu_opc_bus = 17'd1;
      wb = '0;
      pop = 4'b0;
      cur_uop = '0;
      cur_unit = 0;
      n_disp = 0;
      cyc = 0;
      started = 1'b0;
      for (int u = 0; u < 4; u++)
      begin
         front[u] = '0;
         exp_cnt[u] = 0;
      end
      for (int r = 0; r < 32; r++)
      begin
         last_valid[r] = 1'b0;
         last_seq[r] = '0;
      end
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      while (n_disp < N_INSN || queued_total() != 0 || pop != 4'b0)
         @(posedge clk);
      // Let the ROB drain its last commits
      repeat (20) @(posedge clk);
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire
